//--- rtl/system_defs.svh
`ifndef SYSTEM_DEFS_SVH
`define SYSTEM_DEFS_SVH

// cpu bus widths
`define SYS_ADDR_W 16
`define SYS_DATA_W 8

// download port address, wide enough for all rom images
`define DN_ADDR_W 17

// memory array address widths
// program rom 32 KiB at 0x0000
`define PGROM_ADDR_W 15
// work ram 16 KiB at 0xC000
`define WKRAM_ADDR_W 14

// millisecond timer
`define TIMER_W 16
// clk_24 cycles in one millisecond
`define TICKS_PER_MS 24000

// download index of the program rom image
`define DN_INDEX_PGROM 0

// input page codes, cpu address bits 15 to 8
`define PAGE_JOYSTICK 8'h81
`define PAGE_ANALOG_L 8'h82
`define PAGE_ANALOG_R 8'h83
`define PAGE_PADDLE 8'h84
`define PAGE_SPINNER 8'h85
`define PAGE_PS2_KEY 8'h86
`define PAGE_PS2_MOUSE 8'h87
`define PAGE_TIMESTAMP 8'h88
`define PAGE_TIMER 8'h89

`endif

//--- rtl/system_pkg.sv
`default_nettype none

`include "system_defs.svh"

package system_pkg;

	// one byte on the cpu data bus
	typedef logic [`SYS_DATA_W-1:0] byte_t;

	// cpu address
	typedef logic [`SYS_ADDR_W-1:0] cpu_addr_t;

	// download port address
	typedef logic [`DN_ADDR_W-1:0] dn_addr_t;

	// millisecond count
	typedef logic [`TIMER_W-1:0] timer_t;

	// decoded region of a cpu address
	typedef enum logic [3:0] {
		REGION_NONE,
		REGION_PGROM,
		REGION_WKRAM,
		REGION_JOYSTICK,
		REGION_ANALOG_L,
		REGION_ANALOG_R,
		REGION_PADDLE,
		REGION_SPINNER,
		REGION_PS2_KEY,
		REGION_PS2_MOUSE,
		REGION_TIMESTAMP,
		REGION_TIMER
	} region_t;

endpackage

`default_nettype wire

//--- rtl/bus_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "system_defs.svh"

module bus_control (
	input  wire logic                clk_24,
	input  wire logic                rst_n,
	input  system_pkg::cpu_addr_t    cpu_addr,
	input  wire logic                mreq_n,
	input  wire logic                rd_n,
	input  wire logic                wr_n,
	input  system_pkg::byte_t        pgrom_data,
	input  system_pkg::byte_t        wkram_data,
	input  system_pkg::byte_t        port_data,
	output system_pkg::region_t      region,
	output logic                     wkram_wr,
	output logic                     timer_clear,
	output system_pkg::byte_t        rd_data
);

	// memory cycle qualifiers
	logic rd_cycle;
	logic wr_cycle;
	// region of the read sampled on the last edge
	system_pkg::region_t rd_region;

	assign rd_cycle = !mreq_n && !rd_n;
	assign wr_cycle = !mreq_n && !wr_n;

	// address decode
	always_comb
	begin
		region = system_pkg::REGION_NONE;
		if (!cpu_addr[15])
			region = system_pkg::REGION_PGROM;
		else if (cpu_addr[14])
			region = system_pkg::REGION_WKRAM;
		else
		begin
			// 0x8000 to 0xBFFF, one input device per page
			case (cpu_addr[15:8])
				`PAGE_JOYSTICK: region = system_pkg::REGION_JOYSTICK;
				`PAGE_ANALOG_L: region = system_pkg::REGION_ANALOG_L;
				`PAGE_ANALOG_R: region = system_pkg::REGION_ANALOG_R;
				`PAGE_PADDLE: region = system_pkg::REGION_PADDLE;
				`PAGE_SPINNER: region = system_pkg::REGION_SPINNER;
				`PAGE_PS2_KEY: region = system_pkg::REGION_PS2_KEY;
				`PAGE_PS2_MOUSE: region = system_pkg::REGION_PS2_MOUSE;
				`PAGE_TIMESTAMP: region = system_pkg::REGION_TIMESTAMP;
				`PAGE_TIMER: region = system_pkg::REGION_TIMER;
				default: region = system_pkg::REGION_NONE;
			endcase
		end
	end

	// writes act on the edge that samples them
	// rom writes from the cpu are dropped here
	assign wkram_wr = wr_cycle && (region == system_pkg::REGION_WKRAM);
	// any write into the timer page restarts it
	assign timer_clear = wr_cycle && (region == system_pkg::REGION_TIMER);

	// remember what the read addressed, idle cycles read as none
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			rd_region <= system_pkg::REGION_NONE;
		else if (rd_cycle)
			rd_region <= region;
		else
			rd_region <= system_pkg::REGION_NONE;
	end

	// data sources are all registered one cycle after the address
	always_comb
	begin
		case (rd_region)
			system_pkg::REGION_PGROM: rd_data = pgrom_data;
			system_pkg::REGION_WKRAM: rd_data = wkram_data;
			system_pkg::REGION_NONE: rd_data = '0;
			default: rd_data = port_data;
		endcase
	end

	// a z80 never reads and writes in one cycle
	a_rd_wr_exclusive: assert property (@(posedge clk_24) disable iff (!rst_n)
		!mreq_n |-> (rd_n || wr_n));

endmodule

`default_nettype wire

//--- rtl/input_ports.sv
`timescale 1ns/1ns
`default_nettype none

module input_ports (
	input  wire logic              clk_24,
	input  wire logic              rst_n,
	input  system_pkg::cpu_addr_t  cpu_addr,
	input  system_pkg::region_t    region,
	// 6 pads, 32 buttons each
	input  wire logic [191:0]      joystick,
	// 6 sticks, y in the high byte
	input  wire logic [95:0]       analog_l,
	input  wire logic [95:0]       analog_r,
	// 6 paddles, one byte each
	input  wire logic [47:0]       paddle,
	input  wire logic [95:0]       spinner,
	input  wire logic [10:0]       ps2_key,
	input  wire logic [47:0]       ps2_mouse,
	input  wire logic [32:0]       timestamp,
	input  system_pkg::timer_t     count,
	output system_pkg::byte_t      port_data
);

	// vectors padded up to the full byte range of their address bits
	logic [255:0] joystick_ext;
	logic [127:0] analog_l_ext;
	logic [127:0] analog_r_ext;
	logic [63:0] paddle_ext;
	logic [127:0] spinner_ext;
	logic [15:0] ps2_key_ext;
	logic [63:0] ps2_mouse_ext;
	logic [63:0] timestamp_ext;
	// selected byte and whether a device is addressed
	system_pkg::byte_t dev_byte;
	logic dev_sel;

	// bits past the vector width read as zero
	assign joystick_ext = {64'd0, joystick};
	assign analog_l_ext = {32'd0, analog_l};
	assign analog_r_ext = {32'd0, analog_r};
	assign paddle_ext = {16'd0, paddle};
	assign spinner_ext = {32'd0, spinner};
	assign ps2_key_ext = {5'd0, ps2_key};
	assign ps2_mouse_ext = {16'd0, ps2_mouse};
	assign timestamp_ext = {31'd0, timestamp};

	// byte k of the vector, k from the low address bits
	always_comb
	begin
		dev_byte = '0;
		dev_sel = 1'b1;
		case (region)
			system_pkg::REGION_JOYSTICK: dev_byte = joystick_ext[{cpu_addr[4:0], 3'd0} +: 8];
			system_pkg::REGION_ANALOG_L: dev_byte = analog_l_ext[{cpu_addr[3:0], 3'd0} +: 8];
			system_pkg::REGION_ANALOG_R: dev_byte = analog_r_ext[{cpu_addr[3:0], 3'd0} +: 8];
			system_pkg::REGION_PADDLE: dev_byte = paddle_ext[{cpu_addr[2:0], 3'd0} +: 8];
			system_pkg::REGION_SPINNER: dev_byte = spinner_ext[{cpu_addr[3:0], 3'd0} +: 8];
			system_pkg::REGION_PS2_KEY: dev_byte = ps2_key_ext[{cpu_addr[0], 3'd0} +: 8];
			system_pkg::REGION_PS2_MOUSE: dev_byte = ps2_mouse_ext[{cpu_addr[2:0], 3'd0} +: 8];
			system_pkg::REGION_TIMESTAMP: dev_byte = timestamp_ext[{cpu_addr[2:0], 3'd0} +: 8];
			// timer low byte at even, high byte at odd
			system_pkg::REGION_TIMER: dev_byte = count[{cpu_addr[0], 3'd0} +: 8];
			default: dev_sel = 1'b0;
		endcase
	end

	// one cycle to port_data, same as the memories
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			port_data <= '0;
		else if (dev_sel)
			port_data <= dev_byte;
		else
			port_data <= '0;
	end

	// device bytes only load for addresses between rom and work ram
	a_no_mem_region: assert property (@(posedge clk_24) disable iff (!rst_n)
		dev_sel |-> (cpu_addr[15:14] == 2'b10));

endmodule

`default_nettype wire

//--- rtl/ms_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "system_defs.svh"

module ms_timer (
	input  wire logic          clk_24,
	input  wire logic          rst_n,
	input  wire logic          timer_clear,
	output system_pkg::timer_t count
);

	// prescaler sized to hold one millisecond of cycles
	localparam int PRESC_W = $clog2(`TICKS_PER_MS);
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`TICKS_PER_MS - 1);

	logic [PRESC_W-1:0] presc;

	// clear restarts the millisecond from zero
	always_ff @(posedge clk_24)
	begin
		if (!rst_n || timer_clear)
		begin
			presc <= '0;
			count <= '0;
		end
		else if (presc == PRESC_LAST)
		begin
			presc <= '0;
			// wraps after 65535 ms
			count <= count + 1'b1;
		end
		else
		begin
			presc <= presc + 1'b1;
		end
	end

	// outside a clear the count moves by one at most per cycle
	a_count_step: assert property (@(posedge clk_24) disable iff (!rst_n)
		(!$past(timer_clear) && count != $past(count)) |-> (count == $past(count) + 1'b1));

endmodule

`default_nettype wire

//--- rtl/main_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "system_defs.svh"

module main_memory (
	input  wire logic              clk_24,
	input  system_pkg::cpu_addr_t  cpu_addr,
	input  system_pkg::byte_t      cpu_dout,
	input  wire logic              wkram_wr,
	input  system_pkg::dn_addr_t   dn_addr,
	input  system_pkg::byte_t      dn_data,
	input  system_pkg::byte_t      dn_index,
	input  wire logic              dn_wr,
	output system_pkg::byte_t      pgrom_data,
	output system_pkg::byte_t      wkram_data
);

	// program rom, 0x0000 to 0x7FFF
	system_pkg::byte_t pgrom_mem [2**`PGROM_ADDR_W];
	// work ram, 0xC000 to 0xFFFF
	system_pkg::byte_t wkram_mem [2**`WKRAM_ADDR_W];

	logic pgrom_wr;

	// rom image only from its own download index
	assign pgrom_wr = dn_wr && (dn_index == 8'(`DN_INDEX_PGROM));

	// download side writes, cpu side reads
	always_ff @(posedge clk_24)
	begin
		if (pgrom_wr)
			pgrom_mem[dn_addr[`PGROM_ADDR_W-1:0]] <= dn_data;
		pgrom_data <= pgrom_mem[cpu_addr[`PGROM_ADDR_W-1:0]];
	end

	// single port, read returns the old byte on a write
	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
			wkram_mem[cpu_addr[`WKRAM_ADDR_W-1:0]] <= cpu_dout;
		wkram_data <= wkram_mem[cpu_addr[`WKRAM_ADDR_W-1:0]];
	end

	// rom image must fit in 32 KiB
	a_dn_in_range: assert property (@(posedge clk_24)
		pgrom_wr |-> (dn_addr[16:15] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/system_bus.sv
`timescale 1ns/1ns
`default_nettype none

module system_bus (
	input  wire logic              clk_24,
	input  wire logic              rst_n,
	// cpu bus
	input  system_pkg::cpu_addr_t  cpu_addr,
	input  system_pkg::byte_t      cpu_dout,
	input  wire logic              mreq_n,
	input  wire logic              rd_n,
	input  wire logic              wr_n,
	// download port
	input  system_pkg::dn_addr_t   dn_addr,
	input  system_pkg::byte_t      dn_data,
	input  system_pkg::byte_t      dn_index,
	input  wire logic              dn_wr,
	// controller inputs
	input  wire logic [191:0]      joystick,
	input  wire logic [95:0]       analog_l,
	input  wire logic [95:0]       analog_r,
	input  wire logic [47:0]       paddle,
	input  wire logic [95:0]       spinner,
	input  wire logic [10:0]       ps2_key,
	input  wire logic [47:0]       ps2_mouse,
	input  wire logic [32:0]       timestamp,
	output system_pkg::byte_t      rd_data
);

	system_pkg::region_t region;
	logic wkram_wr;
	logic timer_clear;
	system_pkg::byte_t pgrom_data;
	system_pkg::byte_t wkram_data;
	system_pkg::byte_t port_data;
	system_pkg::timer_t count;

	// decode, write enables and read mux
	bus_control bus_control_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.cpu_addr(cpu_addr),
		.mreq_n(mreq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.pgrom_data(pgrom_data),
		.wkram_data(wkram_data),
		.port_data(port_data),
		.region(region),
		.wkram_wr(wkram_wr),
		.timer_clear(timer_clear),
		.rd_data(rd_data)
	);

	// memory mapped controller bytes
	input_ports input_ports_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.cpu_addr(cpu_addr),
		.region(region),
		.joystick(joystick),
		.analog_l(analog_l),
		.analog_r(analog_r),
		.paddle(paddle),
		.spinner(spinner),
		.ps2_key(ps2_key),
		.ps2_mouse(ps2_mouse),
		.timestamp(timestamp),
		.count(count),
		.port_data(port_data)
	);

	ms_timer ms_timer_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.timer_clear(timer_clear),
		.count(count)
	);

	// rom and work ram
	main_memory main_memory_i (
		.clk_24(clk_24),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.wkram_wr(wkram_wr),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_index(dn_index),
		.dn_wr(dn_wr),
		.pgrom_data(pgrom_data),
		.wkram_data(wkram_data)
	);

endmodule

`default_nettype wire

//--- verification/system_bus_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "system_defs.svh"

module system_bus_tb;

	// 40 ns period
	localparam int CLK_PERIOD = 40;
	// negedges allowed for the last read to reach the compare
	localparam int DRAIN_LIMIT = 20;

	logic clk_24;
	logic rst_n;
	system_pkg::cpu_addr_t cpu_addr;
	system_pkg::byte_t cpu_dout;
	logic mreq_n;
	logic rd_n;
	logic wr_n;
	system_pkg::dn_addr_t dn_addr;
	system_pkg::byte_t dn_data;
	system_pkg::byte_t dn_index;
	logic dn_wr;
	logic [191:0] joystick;
	logic [95:0] analog_l;
	logic [95:0] analog_r;
	logic [47:0] paddle;
	logic [95:0] spinner;
	logic [10:0] ps2_key;
	logic [47:0] ps2_mouse;
	logic [32:0] timestamp;
	system_pkg::byte_t rd_data;

	// shadow copies of rom and work ram
	system_pkg::byte_t shadow_rom [2**`PGROM_ADDR_W];
	system_pkg::byte_t shadow_ram [2**`WKRAM_ADDR_W];
	logic [14:0] rom_addrs [$];
	system_pkg::cpu_addr_t ram_addrs [$];

	// timer model, edges since the last clear or reset
	int unsigned model_cycles;

	// read issued on this negedge, with its expected byte
	logic rd_issue;
	system_pkg::byte_t rd_expect;
	// the same read after the sampling edge
	logic chk_valid;
	system_pkg::cpu_addr_t chk_addr;
	system_pkg::byte_t chk_byte;

	// tallies
	int issued = 0;
	int checks = 0;
	int errors = 0;
	int direct_errors = 0;
	int timeouts = 0;
	int test_mark = 0;

	system_bus system_bus_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.mreq_n(mreq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_index(dn_index),
		.dn_wr(dn_wr),
		.joystick(joystick),
		.analog_l(analog_l),
		.analog_r(analog_r),
		.paddle(paddle),
		.spinner(spinner),
		.ps2_key(ps2_key),
		.ps2_mouse(ps2_mouse),
		.timestamp(timestamp),
		.rd_data(rd_data)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk_24 = ~clk_24;
	end

	// byte k of a device vector, zero past its width
	function automatic system_pkg::byte_t vec_byte(input logic [255:0] v, input int width,
		input int k);
		logic [255:0] mask;
		mask = {256{1'b1}} >> (256 - width);
		return 8'((v & mask) >> (8 * k));
	endfunction

	// reference model of one cpu read
	function automatic system_pkg::byte_t expected_byte(input system_pkg::cpu_addr_t addr);
		system_pkg::timer_t ms;
		ms = 16'(model_cycles / `TICKS_PER_MS);
		// rom below 0x8000, ram from 0xC000
		if (!addr[15])
			return shadow_rom[addr[14:0]];
		if (addr[14])
			return shadow_ram[addr[13:0]];
		case (addr[15:8])
			`PAGE_JOYSTICK: return vec_byte(256'(joystick), 192, int'(addr[4:0]));
			`PAGE_ANALOG_L: return vec_byte(256'(analog_l), 96, int'(addr[3:0]));
			`PAGE_ANALOG_R: return vec_byte(256'(analog_r), 96, int'(addr[3:0]));
			`PAGE_PADDLE: return vec_byte(256'(paddle), 48, int'(addr[2:0]));
			`PAGE_SPINNER: return vec_byte(256'(spinner), 96, int'(addr[3:0]));
			`PAGE_PS2_KEY: return vec_byte(256'(ps2_key), 11, int'(addr[0]));
			`PAGE_PS2_MOUSE: return vec_byte(256'(ps2_mouse), 48, int'(addr[2:0]));
			`PAGE_TIMESTAMP: return vec_byte(256'(timestamp), 33, int'(addr[2:0]));
			`PAGE_TIMER: return addr[0] ? ms[15:8] : ms[7:0];
			default: return 8'h00;
		endcase
	endfunction

	// any reset or timer page write restarts the millisecond count
	always @(posedge clk_24)
	begin
		if (!rst_n)
			model_cycles <= 0;
		else if (!mreq_n && !wr_n && cpu_addr[15:8] == `PAGE_TIMER)
			model_cycles <= 0;
		else
			model_cycles <= model_cycles + 1;
	end

	// carry each read past its sampling edge
	always @(posedge clk_24)
	begin
		chk_valid <= rd_issue;
		chk_addr <= cpu_addr;
		chk_byte <= rd_expect;
	end

	// rd_data is stable between rising edges
	always @(negedge clk_24)
	begin
		if (chk_valid)
		begin
			checks++;
			if (rd_data !== chk_byte)
			begin
				errors++;
				$display("Mismatch at %0t ns: rd_data at address %h expected %h got %h",
					$time, chk_addr, chk_byte, rd_data);
			end
		end
	end

	// bus released
	task automatic bus_idle();
		@(negedge clk_24);
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dn_wr = 1'b0;
		rd_issue = 1'b0;
	endtask

	task automatic cpu_read(input system_pkg::cpu_addr_t addr);
		@(negedge clk_24);
		cpu_addr = addr;
		mreq_n = 1'b0;
		rd_n = 1'b0;
		wr_n = 1'b1;
		dn_wr = 1'b0;
		rd_issue = 1'b1;
		rd_expect = expected_byte(addr);
		issued++;
	endtask

	task automatic cpu_write(input system_pkg::cpu_addr_t addr, input system_pkg::byte_t data);
		@(negedge clk_24);
		cpu_addr = addr;
		cpu_dout = data;
		mreq_n = 1'b0;
		rd_n = 1'b1;
		wr_n = 1'b0;
		dn_wr = 1'b0;
		rd_issue = 1'b0;
		// only work ram keeps cpu writes
		if (addr[15:14] == 2'b11)
			shadow_ram[addr[13:0]] = data;
	endtask

	task automatic download(input logic [14:0] addr, input system_pkg::byte_t data,
		input system_pkg::byte_t index);
		@(negedge clk_24);
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		rd_issue = 1'b0;
		dn_addr = {2'b00, addr};
		dn_data = data;
		dn_index = index;
		dn_wr = 1'b1;
		if (index == 8'(`DN_INDEX_PGROM))
			shadow_rom[addr] = data;
	endtask

	// every byte index of one input page
	task automatic read_page(input logic [7:0] page, input int bits);
		for (int k = 0; k < (1 << bits); k++)
			cpu_read({page, 8'(k)});
	endtask

	// wait for the compare to catch up with the driver
	task automatic drain_reads(input string where);
		int guard;
		guard = 0;
		bus_idle();
		while (checks != issued && guard < DRAIN_LIMIT)
		begin
			@(negedge clk_24);
			guard++;
		end
		if (checks != issued)
		begin
			timeouts++;
			$display("Timeout: %0d reads never reached the compare in %s",
				issued - checks, where);
		end
	endtask

	task automatic end_test(input string name);
		int total;
		drain_reads(name);
		total = errors + direct_errors + timeouts;
		$display("test %s finished with %0d errors", name, total - test_mark);
		test_mark = total;
	endtask

	initial
	begin
		logic [14:0] ra;
		system_pkg::cpu_addr_t wa;
		void'($urandom(85));
		rst_n = 1'b0;
		cpu_addr = '0;
		cpu_dout = '0;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dn_addr = '0;
		dn_data = '0;
		dn_index = '0;
		dn_wr = 1'b0;
		joystick = '0;
		analog_l = '0;
		analog_r = '0;
		paddle = '0;
		spinner = '0;
		ps2_key = '0;
		ps2_mouse = '0;
		timestamp = '0;
		rd_issue = 1'b0;
		rd_expect = '0;
		repeat (16) @(negedge clk_24);
		rst_n = 1'b1;

		// reset value, then unmapped holes
		@(negedge clk_24);
		if (rd_data !== 8'h00)
		begin
			direct_errors++;
			$display("Mismatch at %0t ns: rd_data after reset expected 00 got %h", $time, rd_data);
		end
		cpu_read(16'h8000);
		cpu_read(16'h8A10);
		cpu_read(16'hB000);
		end_test("reset and unmapped");

		// rom image through download index 0
		for (int k = 0; k < 24; k++)
		begin
			ra = 15'($urandom());
			rom_addrs.push_back(ra);
			download(ra, 8'($urandom()), 8'(`DN_INDEX_PGROM));
		end
		for (int k = 0; k < rom_addrs.size(); k++)
			cpu_read({1'b0, rom_addrs[k]});
		// other images and cpu writes leave the rom alone
		for (int k = 0; k < rom_addrs.size(); k++)
			download(rom_addrs[k], ~shadow_rom[rom_addrs[k]], 8'(1 + k % 4));
		for (int k = 0; k < rom_addrs.size(); k++)
			cpu_write({1'b0, rom_addrs[k]}, 8'($urandom()));
		for (int k = 0; k < rom_addrs.size(); k++)
			cpu_read({1'b0, rom_addrs[k]});
		end_test("program rom");

		// scattered writes, some overwritten, then back-to-back reads
		for (int k = 0; k < 32; k++)
		begin
			wa = {2'b11, 14'($urandom())};
			ram_addrs.push_back(wa);
			cpu_write(wa, 8'($urandom()));
		end
		for (int k = 0; k < 8; k++)
			cpu_write(ram_addrs[k * 3], 8'($urandom()));
		for (int k = 0; k < ram_addrs.size(); k++)
			cpu_read(ram_addrs[k]);
		end_test("work ram");

		// fresh controller state, all bytes of every page
		bus_idle();
		joystick = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
		analog_l = {$urandom(), $urandom(), $urandom()};
		analog_r = {$urandom(), $urandom(), $urandom()};
		paddle = {16'($urandom()), $urandom()};
		spinner = {$urandom(), $urandom(), $urandom()};
		ps2_key = 11'($urandom());
		ps2_mouse = {16'($urandom()), $urandom()};
		timestamp = {1'($urandom()), $urandom()};
		read_page(`PAGE_JOYSTICK, 5);
		read_page(`PAGE_ANALOG_L, 4);
		read_page(`PAGE_ANALOG_R, 4);
		read_page(`PAGE_PADDLE, 3);
		read_page(`PAGE_SPINNER, 4);
		read_page(`PAGE_PS2_KEY, 1);
		read_page(`PAGE_PS2_MOUSE, 3);
		read_page(`PAGE_TIMESTAMP, 3);
		// holes stay zero with every source loaded
		cpu_read(16'h8000);
		cpu_read(16'h8A10);
		cpu_read(16'hB000);
		end_test("input ports");

		// run past one millisecond so the clear has something to undo
		for (int k = 0; k < `TICKS_PER_MS; k++)
			@(negedge clk_24);
		cpu_read({`PAGE_TIMER, 8'h00});
		// clear by write, count up, clear by reset
		cpu_write({`PAGE_TIMER, 8'h00}, 8'($urandom()));
		cpu_read({`PAGE_TIMER, 8'h00});
		cpu_read({`PAGE_TIMER, 8'h01});
		drain_reads("timer clear");
		// two and a half milliseconds
		for (int k = 0; k < `TICKS_PER_MS * 5 / 2; k++)
			@(negedge clk_24);
		cpu_read({`PAGE_TIMER, 8'h00});
		cpu_read({`PAGE_TIMER, 8'h01});
		drain_reads("timer count");
		rst_n = 1'b0;
		repeat (16) @(negedge clk_24);
		rst_n = 1'b1;
		cpu_read({`PAGE_TIMER, 8'h00});
		cpu_read({`PAGE_TIMER, 8'h01});
		end_test("timer");

		$display("reads checked %0d of %0d, errors %0d, timeouts %0d",
			checks, issued, errors + direct_errors, timeouts);
		if (errors == 0 && direct_errors == 0 && timeouts == 0 && checks == issued)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/system_pkg.sv
rtl/bus_control.sv
rtl/input_ports.sv
rtl/ms_timer.sv
rtl/main_memory.sv
rtl/system_bus.sv
verification/system_bus_tb.sv

//--- Makefile
# Verilator build and run of the system bus testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP ?= system_bus_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
